//--- rtl/cpu_settings.svh
`ifndef CPU_SETTINGS_SVH
`define CPU_SETTINGS_SVH

// machine word, also the instruction width
`define CPU_DATA_W 16

// memory address width, low byte of an instruction
`define CPU_ADDR_W 8

// number of words in main memory
// must stay 2**CPU_ADDR_W so every address field is valid
`define CPU_MEM_DEPTH 256

// instruction field positions
// opcode in 15:12, alu function in 11:8, address in 7:0
`define CPU_OPCODE_W 4
`define CPU_FN_W 4

`endif

//--- rtl/cpu_pkg.sv
`default_nettype none

`include "cpu_settings.svh"

package cpu_pkg;

    // major opcodes, unlisted codes run as no-ops
    typedef enum logic [`CPU_OPCODE_W-1:0] {
        op_halt  = 4'h0,
        op_load  = 4'h1,
        op_store = 4'h2,
        op_alu   = 4'h3,
        op_jump  = 4'h4,
        op_jz    = 4'h5
    } opcode_e;

    // alu functions in their encoding order
    typedef enum logic [`CPU_FN_W-1:0] {
        fn_add  = 4'h0,
        fn_sub  = 4'h1,
        fn_mul  = 4'h2,
        fn_div  = 4'h3,
        fn_shl  = 4'h4,
        fn_shr  = 4'h5,
        fn_rol  = 4'h6,
        fn_ror  = 4'h7,
        fn_and  = 4'h8,
        fn_or   = 4'h9,
        fn_xor  = 4'ha,
        fn_nor  = 4'hb,
        fn_nand = 4'hc,
        fn_xnor = 4'hd,
        fn_gt   = 4'he,
        fn_eq   = 4'hf
    } alu_fn_e;

    // one instruction word as held in ir
    typedef struct packed {
        opcode_e                opcode;
        alu_fn_e                fn;
        logic [`CPU_ADDR_W-1:0] addr;
    } instr_t;

    // per-cycle strobes from the sequencer
    typedef struct packed {
        logic mar_from_pc;
        logic mem_read;
        logic mem_write;
        logic ir_load;
        logic mbr_load;
        logic acc_load_mem;
        logic acc_load_alu;
        logic pc_incr;
        logic pc_jump;
    } ctrl_t;

    // one completed instruction
    // acc is the value after the instruction
    typedef struct packed {
        logic [`CPU_ADDR_W-1:0] pc;
        instr_t                 instr;
        logic [`CPU_DATA_W-1:0] acc;
        logic                   mem_wr;
        logic [`CPU_ADDR_W-1:0] wr_addr;
        logic [`CPU_DATA_W-1:0] wr_data;
    } retire_t;

endpackage

`default_nettype wire

//--- rtl/alu.sv
`default_nettype none

`include "cpu_settings.svh"

module alu (
    input  cpu_pkg::alu_fn_e       fn,
    input  logic [`CPU_DATA_W-1:0] a,
    input  logic [`CPU_DATA_W-1:0] b,
    output logic [`CPU_DATA_W-1:0] result
);

    // full width product, only the low word is kept
    logic [2*`CPU_DATA_W-1:0] product;
    logic [`CPU_DATA_W-1:0]   quotient;

    assign product = a * b;

    // divide by zero saturates to all ones
    assign quotient = (b == '0) ? '1 : a / b;

    always_comb begin
        case (fn)
            cpu_pkg::fn_add:  result = a + b;
            cpu_pkg::fn_sub:  result = a - b;
            cpu_pkg::fn_mul:  result = product[`CPU_DATA_W-1:0];
            cpu_pkg::fn_div:  result = quotient;
            // shifts and rotates work on a alone, b is ignored
            cpu_pkg::fn_shl:  result = {a[`CPU_DATA_W-2:0], 1'b0};
            cpu_pkg::fn_shr:  result = {1'b0, a[`CPU_DATA_W-1:1]};
            cpu_pkg::fn_rol:  result = {a[`CPU_DATA_W-2:0], a[`CPU_DATA_W-1]};
            cpu_pkg::fn_ror:  result = {a[0], a[`CPU_DATA_W-1:1]};
            cpu_pkg::fn_and:  result = a & b;
            cpu_pkg::fn_or:   result = a | b;
            cpu_pkg::fn_xor:  result = a ^ b;
            cpu_pkg::fn_nor:  result = ~(a | b);
            cpu_pkg::fn_nand: result = ~(a & b);
            cpu_pkg::fn_xnor: result = ~(a ^ b);
            // compares return a clean 1 or 0
            cpu_pkg::fn_gt:   result = `CPU_DATA_W'(a > b);
            cpu_pkg::fn_eq:   result = `CPU_DATA_W'(a == b);
            default:          result = '0;
        endcase
    end

    // fn comes from ir, which is reset and only loaded from memory
    // an unknown here means an unloaded word was fetched
    always_comb begin
        assert final (!$isunknown(fn))
            else $error("alu function select is unknown");
    end

endmodule

`default_nettype wire

//--- rtl/main_memory.sv
`default_nettype none

`include "cpu_settings.svh"

module main_memory (
    input  logic                   clk,
    input  logic [`CPU_ADDR_W-1:0] addr,
    input  logic                   wr_en,
    input  logic                   rd_en,
    input  logic [`CPU_DATA_W-1:0] wdata,
    output logic [`CPU_DATA_W-1:0] rdata
);

    // storage, contents undefined until loaded
    logic [`CPU_DATA_W-1:0] mem [`CPU_MEM_DEPTH];

    // single port
    // write lands at the edge, read data follows one cycle later
    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[addr] <= wdata;
        end else if (rd_en) begin
            rdata <= mem[addr];
        end
    end

    // rdata holds its last value when not reading
    // the sequencer relies on that for ir and acc loads

    // one port, so a cycle is either a read or a write
    a_no_rd_wr: assert property (@(posedge clk) !(wr_en && rd_en))
        else $error("memory read and write in the same cycle");

endmodule

`default_nettype wire

//--- rtl/datapath.sv
`default_nettype none

`include "cpu_settings.svh"

module datapath (
    input  logic                   clk,
    input  logic                   arst_n,
    input  cpu_pkg::ctrl_t         ctrl,
    input  logic                   idle,
    input  logic                   start,
    input  logic                   load_en,
    input  logic [`CPU_ADDR_W-1:0] load_addr,
    input  logic [`CPU_DATA_W-1:0] load_data,
    output cpu_pkg::instr_t        instr,
    output logic                   acc_zero,
    output logic [`CPU_ADDR_W-1:0] pc,
    output logic [`CPU_DATA_W-1:0] acc,
    output logic [`CPU_ADDR_W-1:0] mem_wr_addr
);

    localparam int unsigned last_addr = `CPU_MEM_DEPTH - 1;

    logic [`CPU_ADDR_W-1:0] pc_q;
    logic [`CPU_ADDR_W-1:0] instr_pc;
    logic [`CPU_ADDR_W-1:0] mar;
    logic [`CPU_ADDR_W-1:0] mar_d;
    logic [`CPU_DATA_W-1:0] mbr;
    logic [`CPU_DATA_W-1:0] acc_q;
    cpu_pkg::instr_t        ir;
    logic [`CPU_DATA_W-1:0] alu_result;
    logic [`CPU_ADDR_W-1:0] mem_addr;
    logic                   mem_wr_en;
    logic                   mem_rd_en;
    logic [`CPU_DATA_W-1:0] mem_wdata;
    logic [`CPU_DATA_W-1:0] mem_rdata;

    // next address, pc for fetch, operand field for execute
    assign mar_d = ctrl.mar_from_pc ? pc_q : ir.addr;

    // memory port steering
    // load port owns it while idle, the core otherwise
    // reads use the address being latched, writes use mar
    assign mem_addr  = idle ? load_addr : (ctrl.mem_write ? mar : mar_d);
    assign mem_wr_en = idle ? load_en : ctrl.mem_write;
    assign mem_rd_en = idle ? 1'b0 : ctrl.mem_read;
    assign mem_wdata = idle ? load_data : mbr;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            pc_q     <= '0;
            instr_pc <= '0;
            mar      <= '0;
            mbr      <= '0;
            acc_q    <= '0;
            ir       <= '0;
        end else begin
            mar <= mar_d;
            // start restarts the program from address 0 with a clean acc
            if (idle && start) begin
                pc_q  <= '0;
                acc_q <= '0;
            end else begin
                if (ctrl.pc_jump) begin
                    pc_q <= ir.addr;
                end else if (ctrl.pc_incr) begin
                    pc_q <= (pc_q == last_addr[`CPU_ADDR_W-1:0]) ? '0 : pc_q + 1'b1;
                end
                if (ctrl.acc_load_mem) begin
                    acc_q <= mem_rdata;
                end else if (ctrl.acc_load_alu) begin
                    acc_q <= alu_result;
                end
            end
            // pc of the fetched word travels with it for retire
            if (ctrl.ir_load) begin
                ir       <= mem_rdata;
                instr_pc <= pc_q;
            end
            // store data is buffered one cycle ahead of the write
            if (ctrl.mbr_load) begin
                mbr <= acc_q;
            end
        end
    end

    // acc is operand a, the memory word is operand b
    alu i_alu (
        .fn     (ir.fn),
        .a      (acc_q),
        .b      (mem_rdata),
        .result (alu_result)
    );

    main_memory i_main_memory (
        .clk   (clk),
        .addr  (mem_addr),
        .wr_en (mem_wr_en),
        .rd_en (mem_rd_en),
        .wdata (mem_wdata),
        .rdata (mem_rdata)
    );

    assign instr       = ir;
    assign acc_zero    = (acc_q == '0);
    assign pc          = instr_pc;
    assign acc         = acc_q;
    assign mem_wr_addr = mar;

endmodule

`default_nettype wire

//--- rtl/control_fsm.sv
`default_nettype none

module control_fsm (
    input  logic            clk,
    input  logic            arst_n,
    input  logic            start,
    input  cpu_pkg::instr_t instr,
    input  logic            acc_zero,
    output cpu_pkg::ctrl_t  ctrl,
    output logic            idle,
    output logic            halted,
    output logic            retire_valid
);

    typedef enum logic [2:0] {
        s_idle,
        s_fetch_addr,
        s_fetch_data,
        s_exec_addr,
        s_exec_done
    } state_e;

    state_e state;
    state_e state_d;
    logic   retire_q;

    // decoded opcode shorthands
    logic is_load;
    logic is_store;
    logic is_alu;
    logic is_halt;
    logic take_jump;

    assign is_load  = (instr.opcode == cpu_pkg::op_load);
    assign is_store = (instr.opcode == cpu_pkg::op_store);
    assign is_alu   = (instr.opcode == cpu_pkg::op_alu);
    assign is_halt  = (instr.opcode == cpu_pkg::op_halt);
    // jz looks at acc as left by the previous instruction
    assign take_jump = (instr.opcode == cpu_pkg::op_jump) ||
                       ((instr.opcode == cpu_pkg::op_jz) && acc_zero);

    always_comb begin
        ctrl    = '0;
        state_d = state;
        case (state)
            s_idle: begin
                if (start) begin
                    state_d = s_fetch_addr;
                end
            end
            // read the word at pc
            s_fetch_addr: begin
                ctrl.mar_from_pc = 1'b1;
                ctrl.mem_read    = 1'b1;
                state_d          = s_fetch_data;
            end
            // latch it into ir, step pc
            s_fetch_data: begin
                ctrl.ir_load = 1'b1;
                ctrl.pc_incr = 1'b1;
                state_d      = s_exec_addr;
            end
            // operand read, or stage acc for a store
            s_exec_addr: begin
                ctrl.mem_read = is_load || is_alu;
                ctrl.mbr_load = is_store;
                state_d       = s_exec_done;
            end
            s_exec_done: begin
                ctrl.acc_load_mem = is_load;
                ctrl.acc_load_alu = is_alu;
                ctrl.mem_write    = is_store;
                ctrl.pc_jump      = take_jump;
                state_d           = is_halt ? s_idle : s_fetch_addr;
            end
            default: begin
                state_d = s_idle;
            end
        endcase
    end

    // retire is flagged one cycle after exec_done
    // so the record shows acc after the update
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state    <= s_idle;
            retire_q <= 1'b0;
        end else begin
            state    <= state_d;
            retire_q <= (state == s_exec_done);
        end
    end

    assign idle         = (state == s_idle);
    assign halted       = (state == s_idle);
    assign retire_valid = retire_q;

    a_rd_wr_excl: assert property (
        @(posedge clk) disable iff (!arst_n)
        !(ctrl.mem_read && ctrl.mem_write)
    ) else $error("read and write strobes together");

    // a retire seen while idle can only be the halt that got us here
    a_idle_retire: assert property (
        @(posedge clk) disable iff (!arst_n)
        (retire_valid && idle) |-> is_halt
    ) else $error("retire while idle without a halt");

endmodule

`default_nettype wire

//--- rtl/accumulator_computer.sv
`default_nettype none

`include "cpu_settings.svh"

module accumulator_computer (
    input  logic                   clk,
    input  logic                   arst_n,
    input  logic                   load_en,
    input  logic [`CPU_ADDR_W-1:0] load_addr,
    input  logic [`CPU_DATA_W-1:0] load_data,
    input  logic                   start,
    output logic                   halted,
    output logic                   retire_valid,
    output cpu_pkg::retire_t       retire
);

    cpu_pkg::ctrl_t         ctrl;
    cpu_pkg::instr_t        instr;
    logic                   idle;
    logic                   acc_zero;
    logic [`CPU_ADDR_W-1:0] pc;
    logic [`CPU_DATA_W-1:0] acc;
    logic [`CPU_ADDR_W-1:0] mem_wr_addr;

    control_fsm i_control_fsm (
        .clk          (clk),
        .arst_n       (arst_n),
        .start        (start),
        .instr        (instr),
        .acc_zero     (acc_zero),
        .ctrl         (ctrl),
        .idle         (idle),
        .halted       (halted),
        .retire_valid (retire_valid)
    );

    datapath i_datapath (
        .clk         (clk),
        .arst_n      (arst_n),
        .ctrl        (ctrl),
        .idle        (idle),
        .start       (start),
        .load_en     (load_en),
        .load_addr   (load_addr),
        .load_data   (load_data),
        .instr       (instr),
        .acc_zero    (acc_zero),
        .pc          (pc),
        .acc         (acc),
        .mem_wr_addr (mem_wr_addr)
    );

    // ir, its pc, acc and mar still describe the retiring instruction
    // store data equals acc, since a store leaves acc unchanged
    assign retire = '{
        pc:      pc,
        instr:   instr,
        acc:     acc,
        mem_wr:  (instr.opcode == cpu_pkg::op_store),
        wr_addr: mem_wr_addr,
        wr_data: acc
    };

endmodule

`default_nettype wire

//--- dv/tb_checker.sv
`default_nettype none

`include "cpu_settings.svh"

module tb_checker (
    input  logic                   clk,
    input  logic                   arst_n,
    input  logic                   load_en,
    input  logic [`CPU_ADDR_W-1:0] load_addr,
    input  logic [`CPU_DATA_W-1:0] load_data,
    input  logic                   start,
    input  logic                   halted,
    input  logic                   retire_valid,
    input  cpu_pkg::retire_t       retire,
    output int                     error_count,
    output int                     retire_count
);
    timeunit 1ns;
    timeprecision 1ps;

    // instruction-set model state
    logic [`CPU_DATA_W-1:0] model_mem [`CPU_MEM_DEPTH];
    logic [`CPU_ADDR_W-1:0] model_pc;
    logic [`CPU_DATA_W-1:0] model_acc;
    logic                   running;
    logic                   first_retire;
    int                     gap;

    // function codes in instruction-set order
    function automatic logic [15:0] alu_model(input logic [3:0] fn, input logic [15:0] a,
                                              input logic [15:0] b);
        logic [31:0] wide;
        wide = {16'h0, a} * {16'h0, b};
        case (fn)
            4'h0: return a + b;
            4'h1: return a - b;
            4'h2: return wide[15:0];
            4'h3: return (b == 16'h0) ? 16'hffff : a / b;
            4'h4: return a << 1;
            4'h5: return a >> 1;
            4'h6: return (a << 1) | (a >> 15);
            4'h7: return (a >> 1) | (a << 15);
            4'h8: return a & b;
            4'h9: return a | b;
            4'ha: return a ^ b;
            4'hb: return ~a & ~b;
            4'hc: return ~a | ~b;
            4'hd: return (a & b) | (~a & ~b);
            4'he: return (a > b) ? 16'h1 : 16'h0;
            default: return (a == b) ? 16'h1 : 16'h0;
        endcase
    endfunction

    task automatic report(input string what);
        $display("error at %0t: %s", $time, what);
        error_count++;
    endtask

    task automatic expect_equal(input string field, input logic [15:0] got,
                                input logic [15:0] exp);
        if (got !== exp) begin
            $display("error at %0t: retire %s got %h expected %h", $time, field, got, exp);
            error_count++;
        end
    endtask

    task automatic check_retire();
        cpu_pkg::instr_t        ins;
        logic [`CPU_ADDR_W-1:0] next_pc;
        logic                   exp_wr;
        ins     = cpu_pkg::instr_t'(model_mem[model_pc]);
        next_pc = model_pc + 8'd1;
        exp_wr  = 1'b0;
        retire_count++;
        // 5 cycles from the start pulse, 4 per instruction after that
        expect_equal("spacing", 16'(gap), first_retire ? 16'd5 : 16'd4);
        expect_equal("pc", 16'(retire.pc), 16'(model_pc));
        expect_equal("instr", retire.instr, ins);
        case (ins.opcode)
            cpu_pkg::op_halt:  running = 1'b0;
            cpu_pkg::op_load:  model_acc = model_mem[ins.addr];
            cpu_pkg::op_alu:   model_acc = alu_model(ins.fn, model_acc, model_mem[ins.addr]);
            cpu_pkg::op_jump:  next_pc = ins.addr;
            cpu_pkg::op_jz:    next_pc = (model_acc == 16'h0) ? ins.addr : next_pc;
            cpu_pkg::op_store: begin
                model_mem[ins.addr] = model_acc;
                exp_wr              = 1'b1;
            end
            default: ;
        endcase
        expect_equal("acc", retire.acc, model_acc);
        expect_equal("mem_wr", 16'(retire.mem_wr), 16'(exp_wr));
        if (exp_wr) begin
            expect_equal("wr_addr", 16'(retire.wr_addr), 16'(ins.addr));
            expect_equal("wr_data", retire.wr_data, model_acc);
        end
        // halted rises together with the halt retire and not before
        expect_equal("halted", 16'(halted), 16'(ins.opcode == cpu_pkg::op_halt));
        model_pc     = next_pc;
        first_retire = 1'b0;
        gap          = 0;
    endtask

    // sample in mid cycle, inputs and outputs are all settled
    always @(negedge clk) begin
        if (!arst_n) begin
            error_count  = 0;
            retire_count = 0;
            running      = 1'b0;
            first_retire = 1'b0;
            gap          = 0;
        end else begin
            gap++;
            // port writes only land while the machine is idle
            if (load_en && halted) begin
                model_mem[load_addr] = load_data;
            end
            if (start && halted) begin
                model_pc     = '0;
                model_acc    = '0;
                running      = 1'b1;
                first_retire = 1'b1;
                gap          = 0;
            end
            if (retire_valid && !running) begin
                report("an instruction retired while no program was running");
            end else if (retire_valid) begin
                check_retire();
            end else if (running && gap > 0 && halted) begin
                report("machine halted before a halt instruction retired");
                running = 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

//--- dv/tb_top.sv
`default_nettype none

`include "cpu_settings.svh"

module tb_top;
    timeunit 1ns;
    timeprecision 1ps;

    // one run is a full image load plus a full code area at 4 cycles each
    localparam int run_cycles  = `CPU_MEM_DEPTH + 4 * 128 + 16;
    localparam int num_runs    = 6;
    localparam int cycle_limit = run_cycles * num_runs + 200;

    // branch test mix: alu, load, jump, jz, two unused opcodes as no-ops
    localparam logic [3:0] op_mix [8] = '{4'h3, 4'h3, 4'h1, 4'h4, 4'h5, 4'h5, 4'h6, 4'hb};
    // div, the four shifts, gt, eq
    localparam logic [3:0] edge_fn [7] = '{4'h3, 4'h4, 4'h5, 4'h6, 4'h7, 4'he, 4'hf};
    localparam logic [15:0] edge_val [4] = '{16'h0000, 16'h8000, 16'h0001, 16'hffff};

    logic                   clk = 1'b0;
    logic                   arst_n;
    logic                   load_en;
    logic [`CPU_ADDR_W-1:0] load_addr;
    logic [`CPU_DATA_W-1:0] load_data;
    logic                   start;
    logic                   halted;
    logic                   retire_valid;
    cpu_pkg::retire_t       retire;
    int                     error_count;
    int                     retire_count;
    int                     cycle_count;
    int                     pass_tests;
    int                     fail_tests;
    logic [31:0]            rng;
    logic [`CPU_DATA_W-1:0] image [`CPU_MEM_DEPTH];

    always #2 clk = ~clk;

    accumulator_computer i_dut (
        .clk          (clk),
        .arst_n       (arst_n),
        .load_en      (load_en),
        .load_addr    (load_addr),
        .load_data    (load_data),
        .start        (start),
        .halted       (halted),
        .retire_valid (retire_valid),
        .retire       (retire)
    );

    tb_checker i_checker (
        .clk          (clk),
        .arst_n       (arst_n),
        .load_en      (load_en),
        .load_addr    (load_addr),
        .load_data    (load_data),
        .start        (start),
        .halted       (halted),
        .retire_valid (retire_valid),
        .retire       (retire),
        .error_count  (error_count),
        .retire_count (retire_count)
    );

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        return y ^ (y << 5);
    endfunction

    function automatic logic [31:0] next_random();
        rng = xorshift32(rng);
        return rng;
    endfunction

    // mode 1 alu, 2 store and load, 3 branches, 4 edge operands
    task automatic build_program(input int mode, input int len);
        logic [31:0] r;
        logic [3:0]  op;
        logic [3:0]  fn;
        logic [7:0]  a;
        for (int i = 0; i < `CPU_MEM_DEPTH; i++) begin
            r  = next_random();
            fn = (mode == 4) ? edge_fn[(i / 2) % 7] : r[11:8];
            // store test keeps to 16 data words so loads hit earlier stores
            a  = (mode == 2) ? {4'h8, r[19:16]} : {1'b1, r[22:16]};
            if (mode == 1) begin
                op = (i % 4 == 0) ? 4'h1 : 4'h3;
            end else if (mode == 2) begin
                op = (r[25:24] == 2'd0) ? 4'h1 : ((r[25:24] == 2'd1) ? 4'h2 : 4'h3);
            end else if (mode == 3) begin
                op = op_mix[r[27:25]];
            end else begin
                op = i[0] ? 4'h3 : 4'h1;
                // alu operands sweep the edge words so every function meets each one
                if (i[0]) begin
                    a = 8'(128 + (i / 2) % 4);
                end
            end
            // forward target, at most the closing halt
            if ((op == 4'h4 || op == 4'h5) && i < len) begin
                a = 8'(i + 1 + int'(r[23:16]) % (len - i));
            end
            if (i >= 128) begin
                // a share of zero words so jz gets taken
                image[i] = (mode == 4) ? edge_val[i % 4] :
                           ((r[31:29] == 3'd0) ? 16'h0000 : r[15:0]);
            end else if (i >= len) begin
                image[i] = {4'h0, 4'h0, 8'(i)};
            end else begin
                image[i] = {op, fn, a};
            end
        end
    endtask

    task automatic load_words(input int first, input int last);
        for (int i = first; i <= last; i++) begin
            @(posedge clk);
            load_en   <= 1'b1;
            load_addr <= 8'(i);
            load_data <= image[i];
        end
        @(posedge clk);
        load_en <= 1'b0;
    endtask

    task automatic run_program(input string name);
        int errors_before;
        int retires_before;
        errors_before  = error_count;
        retires_before = retire_count;
        @(posedge clk);
        start <= 1'b1;
        @(posedge clk);
        start <= 1'b0;
        @(negedge clk);
        while (!halted) begin
            @(negedge clk);
        end
        // let the checker finish the halt retire first
        @(posedge clk);
        if (error_count == errors_before && retire_count > retires_before) begin
            pass_tests++;
        end else begin
            fail_tests++;
        end
        $display("test %s: %0d retires, %0d errors", name,
                 retire_count - retires_before, error_count - errors_before);
    endtask

    task automatic full_test(input int mode, input int len, input string name);
        build_program(mode, len);
        load_words(0, `CPU_MEM_DEPTH - 1);
        run_program(name);
    endtask

    initial begin : watchdog
        cycle_count = 0;
        while (cycle_count < cycle_limit) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("timeout: the run did not finish within %0d cycles", cycle_limit);
        $display("Test failed");
        $finish;
    end

    initial begin
        rng        = 32'ha7d5cbaa;
        arst_n     = 1'b0;
        load_en    = 1'b0;
        load_addr  = '0;
        load_data  = '0;
        start      = 1'b0;
        pass_tests = 0;
        fail_tests = 0;
        repeat (3) @(posedge clk);
        arst_n <= 1'b1;
        full_test(1, 100, "alu functions");
        full_test(3, 120, "jumps and jz");
        full_test(4, 90, "edge operands");
        full_test(2, 110, "store and load");
        // same memory again, stores from the last run stay in place
        run_program("restart without reload");
        for (int i = 128; i < 136; i++) begin
            image[i] = 16'(next_random());
        end
        load_words(128, 135);
        run_program("reload while halted");
        $display("passing tests: %0d, failing tests: %0d", pass_tests, fail_tests);
        if (fail_tests == 0 && error_count == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- sim.f
+incdir+rtl
rtl/cpu_pkg.sv
rtl/alu.sv
rtl/main_memory.sv
rtl/datapath.sv
rtl/control_fsm.sv
rtl/accumulator_computer.sv
dv/tb_checker.sv
dv/tb_top.sv

//--- Makefile
# Verilator build and run of the accumulator computer testbench

BUILD := obj_dir

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run the testbench, check for a pass"
	@echo "  clean  remove the build directory"

test:
	verilator --binary --timing --assert -Wno-fatal --top-module tb_top \
		-Mdir $(BUILD) -f sim.f
	out="$$(./$(BUILD)/Vtb_top)"; echo "$$out"; echo "$$out" | grep -qx "Test passed"

clean:
	rm -rf $(BUILD)
